// File: aes_api.sv
`timescale 1ns/1ps

module aes_api (
    input  logic             clk,
    input  logic             i_reset,
    input  logic             i_valid,
    input  logic             i_new,
    input  logic             i_last,
    input  aes_pkg::key_t    i_key,
    input  aes_pkg::iv_t     i_iv,
    input  aes_pkg::block_t  i_plain_text,
    input  aes_pkg::bypass_t i_bypass_text,
    output logic             o_busy,
    output logic             o_cp_ready,
    output aes_pkg::block_t  o_cipher_text,
    output aes_pkg::bypass_t o_bypass_text,
    output logic             o_last
);
    import aes_pkg::*;

    logic   start;       // Accepted block
    key_t   start_key;
    ctr_t   start_ctr;   // Counter block for this block
    logic   start_last;
    logic   core_done;
    block_t keystream;

    ctr_config u_ctr_config (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_valid     (i_valid),
        .i_new       (i_new),
        .i_last      (i_last),
        .i_key       (i_key),
        .i_iv        (i_iv),
        .i_core_busy (o_busy),
        .o_start     (start),
        .o_key       (start_key),
        .o_ctr       (start_ctr),
        .o_last      (start_last)
    );

    aes_core u_aes_core (
        .clk     (clk),
        .i_reset (i_reset),
        .i_start (start),
        .i_key   (start_key),
        .i_block (start_ctr),
        .o_busy  (o_busy),
        .o_done  (core_done),
        .o_block (keystream)
    );

    gcm_output_stage u_gcm_output_stage (
        .clk           (clk),
        .i_reset       (i_reset),
        .i_capture     (start),
        .i_last        (start_last),
        .i_plain_text  (i_plain_text),
        .i_bypass_text (i_bypass_text),
        .i_done        (core_done),
        .i_keystream   (keystream),
        .o_cipher_text (o_cipher_text),
        .o_bypass_text (o_bypass_text),
        .o_last        (o_last),
        .o_cp_ready    (o_cp_ready)
    );

endmodule

// File: aes_core.sv
`timescale 1ns/1ps

module aes_core (
    input  logic            clk,
    input  logic            i_reset,
    input  logic            i_start,
    input  aes_pkg::key_t   i_key,
    input  aes_pkg::ctr_t   i_block,   // Counter block to encrypt
    output logic            o_busy,
    output logic            o_done,    // One cycle, keystream valid
    output aes_pkg::block_t o_block
);
    import aes_pkg::*;

    core_state_t state_q;
    round_t      round_q;      // Round applied at the next edge
    logic        done_q;
    logic        busy_q;
    block_t      state_blk_q;  // AES state between rounds
    key_t        round_key_q;  // Key of the last applied round

    logic [31:0] w0;
    logic [31:0] w1;
    logic [31:0] w2;
    logic [31:0] w3;
    logic [31:0] key_temp;
    key_t        key_next;
    block_t      sub_blk;
    block_t      shift_blk;
    block_t      mix_blk;
    block_t      round_out;

    // On-the-fly key schedule, one round key per cycle
    always_comb
    begin
        w0       = round_key_q[127:96];
        w1       = round_key_q[95:64];
        w2       = round_key_q[63:32];
        w3       = round_key_q[31:0];
        key_temp = sub_word({w3[23:0], w3[31:24]}) ^ {rcon_byte(round_q), 24'h000000};
        key_next[127:96] = w0 ^ key_temp;
        key_next[95:64]  = w1 ^ w0 ^ key_temp;
        key_next[63:32]  = w2 ^ w1 ^ w0 ^ key_temp;
        key_next[31:0]   = w3 ^ w2 ^ w1 ^ w0 ^ key_temp;
    end

    // One full round
    always_comb
    begin
        sub_blk   = sub_bytes(state_blk_q);
        shift_blk = shift_rows(sub_blk);
        mix_blk   = (round_q == NUM_ROUNDS) ? shift_blk : mix_columns(shift_blk);  // No mix in final
        round_out = mix_blk ^ key_next;
    end

    always_ff @(posedge clk)
    begin
        if (i_reset)
        begin
            state_q <= IDLE;
            round_q <= '0;
            done_q  <= 1'b0;
            busy_q  <= 1'b0;
        end
        else
        begin
            done_q <= 1'b0;
            busy_q <= (state_q == ROUND);  // Lags by one, covers output register cycle
            case (state_q)
                IDLE:
                begin
                    if (i_start)
                    begin
                        state_q <= ROUND;
                        round_q <= 4'd1;
                    end
                end
                ROUND:
                begin
                    if (round_q == NUM_ROUNDS)
                    begin
                        state_q <= IDLE;
                        round_q <= '0;
                        done_q  <= 1'b1;  // State now holds keystream
                    end
                    else
                    begin
                        round_q <= round_q + 4'd1;
                    end
                end
                default:
                begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state_q == IDLE && i_start)
        begin
            state_blk_q <= i_block ^ i_key;  // Initial AddRoundKey
            round_key_q <= i_key;
        end
        else if (state_q == ROUND)
        begin
            state_blk_q <= round_out;
            round_key_q <= key_next;
        end
    end

    assign o_busy  = busy_q;
    assign o_done  = done_q;
    assign o_block = state_blk_q;  // Holds until next start

    a_done_single: assert property (@(posedge clk) disable iff (i_reset)
        o_done |=> !o_done);

    a_round_range: assert property (@(posedge clk) disable iff (i_reset)
        round_q <= NUM_ROUNDS);

endmodule

// File: aes_pkg.sv
package aes_pkg;

    typedef logic [127:0] block_t;  // State, plaintext, ciphertext or keystream
    typedef logic [127:0] key_t;    // Cipher key or round key
    typedef logic [95:0]  iv_t;     // GCM initialization vector
    typedef logic [127:0] ctr_t;    // IV followed by 32-bit block counter
    typedef logic [127:0] bypass_t; // Header word, passed through untouched
    typedef logic [3:0]   round_t;  // Round index 0..10

    typedef enum logic
    {
        IDLE,
        ROUND
    } core_state_t;

    localparam round_t      NUM_ROUNDS = 4'd10;  // AES-128
    localparam logic [31:0] CTR_START  = 32'd2;  // First data block per GCM, J0 + 1

    // Forward S-box, entry 0 in the top byte
    localparam logic [2047:0] SBOX =
    {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    function automatic logic [7:0] sbox_byte(input logic [7:0] b);
        return SBOX[2047 - 8 * int'(b) -: 8];  // Byte b of the table
    endfunction

    function automatic logic [31:0] sub_word(input logic [31:0] w);
        logic [31:0] r;
        for (int i = 0; i < 4; i++)
        begin
            r[31 - 8 * i -: 8] = sbox_byte(w[31 - 8 * i -: 8]);
        end
        return r;
    endfunction

    function automatic block_t sub_bytes(input block_t s);
        block_t r;
        for (int i = 0; i < 16; i++)
        begin
            r[127 - 8 * i -: 8] = sbox_byte(s[127 - 8 * i -: 8]);
        end
        return r;
    endfunction

    // Byte i sits at row i%4, column i/4; row r rotates left by r
    function automatic block_t shift_rows(input block_t s);
        block_t r;
        int     src;
        for (int c = 0; c < 4; c++)
        begin
            for (int row = 0; row < 4; row++)
            begin
                src = row + 4 * ((c + row) % 4);  // Source byte index
                r[127 - 8 * (row + 4 * c) -: 8] = s[127 - 8 * src -: 8];
            end
        end
        return r;
    endfunction

    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);  // Multiply by x in GF(2^8)
    endfunction

    function automatic block_t mix_columns(input block_t s);
        block_t     r;
        logic [7:0] a0;
        logic [7:0] a1;
        logic [7:0] a2;
        logic [7:0] a3;
        for (int c = 0; c < 4; c++)
        begin
            a0 = s[127 - 32 * c -: 8];
            a1 = s[119 - 32 * c -: 8];
            a2 = s[111 - 32 * c -: 8];
            a3 = s[103 - 32 * c -: 8];
            // Rows of the {02 03 01 01} circulant
            r[127 - 32 * c -: 8] = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
            r[119 - 32 * c -: 8] = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
            r[111 - 32 * c -: 8] = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
            r[103 - 32 * c -: 8] = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
        end
        return r;
    endfunction

    // Round constant for key expansion step 1..10
    function automatic logic [7:0] rcon_byte(input round_t rnd);
        logic [7:0] r;
        case (rnd)
            4'd1:    r = 8'h01;
            4'd2:    r = 8'h02;
            4'd3:    r = 8'h04;
            4'd4:    r = 8'h08;
            4'd5:    r = 8'h10;
            4'd6:    r = 8'h20;
            4'd7:    r = 8'h40;
            4'd8:    r = 8'h80;
            4'd9:    r = 8'h1b;
            4'd10:   r = 8'h36;
            default: r = 8'h00;  // Round 0 has no expansion step
        endcase
        return r;
    endfunction

endpackage

// File: ctr_config.sv
`timescale 1ns/1ps

module ctr_config (
    input  logic           clk,
    input  logic           i_reset,
    input  logic           i_valid,      // One block offered
    input  logic           i_new,        // First block of a message
    input  logic           i_last,       // Final block of a message
    input  aes_pkg::key_t  i_key,
    input  aes_pkg::iv_t   i_iv,
    input  logic           i_core_busy,
    output logic           o_start,      // Accepted block, same cycle
    output aes_pkg::key_t  o_key,
    output aes_pkg::ctr_t  o_ctr,
    output logic           o_last
);
    import aes_pkg::*;

    key_t        key_q;   // Message key
    iv_t         iv_q;    // Message IV
    logic [31:0] cnt_q;   // Counter for the next block
    logic        open_q;  // Message in progress

    logic        accept;

    // New message always accepted, continuation only while open
    assign accept  = i_valid && (i_new || open_q);
    assign o_start = accept;
    assign o_last  = i_last;

    // First block bypasses the registers so the core starts at once
    assign o_key = i_new ? i_key : key_q;
    assign o_ctr = i_new ? {i_iv, CTR_START} : {iv_q, cnt_q};

    always_ff @(posedge clk)
    begin
        if (i_reset)
        begin
            open_q <= 1'b0;
        end
        else if (accept)
        begin
            open_q <= !i_last;  // Last block closes the message
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            if (i_new)
            begin
                key_q <= i_key;
                iv_q  <= i_iv;
                cnt_q <= CTR_START + 32'd1;  // Second block uses 3
            end
            else
            begin
                cnt_q <= cnt_q + 32'd1;  // Wraps modulo 2^32
            end
        end
    end

    // Source must wait for the previous block to leave
    a_no_valid_when_busy: assert property (@(posedge clk) disable iff (i_reset)
        i_valid |-> !i_core_busy);

    // Core raises busy two edges after the start strobe
    a_start_then_busy: assert property (@(posedge clk) disable iff (i_reset)
        o_start |-> !i_core_busy ##2 i_core_busy);

endmodule

// File: gcm_input.txt
# valid new last key iv plaintext bypass, then expected ciphertext or the word dropped
# GCM test cases 3 and 2 with byte 0 leftmost; bypass is a tag that gets a random word mixed in
1 1 0 feffe9928665731c6d6a8f9467308308 cafebabefacedbaddecaf888 d9313225f88406e5a55909c5aff5269a 4500000000000000000000000000a001 42831ec2217774244b7221b784d0d49c
1 0 0 feffe9928665731c6d6a8f9467308308 cafebabefacedbaddecaf888 86a7a9531534f7da2e4c303d8a318a72 4500000000000000000000000000a002 e3aa212f2c02a4e035c17e2329aca12e
1 0 0 feffe9928665731c6d6a8f9467308308 cafebabefacedbaddecaf888 1c3c0c95956809532fcf0e2449a6b525 4500000000000000000000000000a003 21d514b25466931c7d8f6a5aac84aa05
1 0 1 feffe9928665731c6d6a8f9467308308 cafebabefacedbaddecaf888 b16aedf5aa0de657ba637b391aafd255 4500000000000000000000000000a004 1ba30b396a0aac973d58e091473f5985
1 0 0 feffe9928665731c6d6a8f9467308308 cafebabefacedbaddecaf888 d9313225f88406e5a55909c5aff5269a 4500000000000000000000000000a005 dropped
1 1 1 00000000000000000000000000000000 000000000000000000000000 00000000000000000000000000000000 4500000000000000000000000000b001 0388dace60b6a392f328c2b971b2fe78
1 0 1 00000000000000000000000000000000 000000000000000000000000 00000000000000000000000000000000 4500000000000000000000000000b002 dropped
0 0 0 00000000000000000000000000000000 000000000000000000000000 00000000000000000000000000000000 4500000000000000000000000000b003 dropped
1 1 0 feffe9928665731c6d6a8f9467308308 cafebabefacedbaddecaf888 d9313225f88406e5a55909c5aff5269a 4500000000000000000000000000c001 42831ec2217774244b7221b784d0d49c
1 1 0 feffe9928665731c6d6a8f9467308308 cafebabefacedbaddecaf888 d9313225f88406e5a55909c5aff5269a 4500000000000000000000000000c002 42831ec2217774244b7221b784d0d49c
1 0 1 feffe9928665731c6d6a8f9467308308 cafebabefacedbaddecaf888 86a7a9531534f7da2e4c303d8a318a72 4500000000000000000000000000c003 e3aa212f2c02a4e035c17e2329aca12e
1 1 1 00000000000000000000000000000000 000000000000000000000000 00000000000000000000000000000000 4500000000000000000000000000d001 0388dace60b6a392f328c2b971b2fe78

// File: gcm_output_stage.sv
`timescale 1ns/1ps

module gcm_output_stage (
    input  logic             clk,
    input  logic             i_reset,
    input  logic             i_capture,      // Block accepted
    input  logic             i_last,
    input  aes_pkg::block_t  i_plain_text,
    input  aes_pkg::bypass_t i_bypass_text,
    input  logic             i_done,         // Keystream ready
    input  aes_pkg::block_t  i_keystream,
    output aes_pkg::block_t  o_cipher_text,
    output aes_pkg::bypass_t o_bypass_text,
    output logic             o_last,
    output logic             o_cp_ready      // One cycle, outputs valid
);
    import aes_pkg::*;

    block_t  plain_q;   // Plaintext waiting for keystream
    bypass_t bypass_q;  // Header word of the same block
    logic    last_q;

    // Hold block data while the core runs
    always_ff @(posedge clk)
    begin
        if (i_capture)
        begin
            plain_q  <= i_plain_text;
            bypass_q <= i_bypass_text;
            last_q   <= i_last;
        end
    end

    always_ff @(posedge clk)
    begin
        if (i_reset)
        begin
            o_cipher_text <= '0;
            o_bypass_text <= '0;
            o_last        <= 1'b0;
            o_cp_ready    <= 1'b0;
        end
        else
        begin
            o_cp_ready <= i_done;
            if (i_done)
            begin
                o_cipher_text <= plain_q ^ i_keystream;  // CTR encryption
                o_bypass_text <= bypass_q;
                o_last        <= last_q;
            end
        end
    end

endmodule

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_aes_api -f sim.f -o tb_aes_api_sim &&
./obj_dir/tb_aes_api_sim ||
exit 1

// File: sim.f
aes_pkg.sv
ctr_config.sv
aes_core.sv
gcm_output_stage.sv
aes_api.sv
tb_aes_api.sv

// File: tb_aes_api.sv
`timescale 1ns/1ps

module tb_aes_api;
    import aes_pkg::*;

    localparam int READY_LIMIT = 16;  // Cycles allowed before a block counts as lost

    logic    clk;
    logic    i_reset;
    logic    i_valid;
    logic    i_new;
    logic    i_last;
    key_t    i_key;
    iv_t     i_iv;
    block_t  i_plain_text;
    bypass_t i_bypass_text;
    logic    o_busy;
    logic    o_cp_ready;
    block_t  o_cipher_text;
    bypass_t o_bypass_text;
    logic    o_last;

    logic    vec_valid[$];   // Columns of gcm_input.txt
    logic    vec_new[$];
    logic    vec_last[$];
    key_t    vec_key[$];
    iv_t     vec_iv[$];
    block_t  vec_plain[$];
    bypass_t vec_bypass[$];  // Header tag, mixed with a random word
    block_t  vec_expect[$];
    logic    vec_drop[$];    // Block must leave no trace
    int      num_vec;
    logic    loaded;

    aes_api aes_api_i (
        .clk           (clk),
        .i_reset       (i_reset),
        .i_valid       (i_valid),
        .i_new         (i_new),
        .i_last        (i_last),
        .i_key         (i_key),
        .i_iv          (i_iv),
        .i_plain_text  (i_plain_text),
        .i_bypass_text (i_bypass_text),
        .o_busy        (o_busy),
        .o_cp_ready    (o_cp_ready),
        .o_cipher_text (o_cipher_text),
        .o_bypass_text (o_bypass_text),
        .o_last        (o_last)
    );

    initial
    begin
        clk = 1'b0;
    end

    always #50 clk = ~clk;  // 100 ns period

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
        if (actual !== expected)
        begin
            abort_run($sformatf("mismatch at %0t: %s is %h, expected %h",
                                $time, name, actual, expected));
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          code;
        string       line;
        logic        v;
        logic        n;
        logic        l;
        key_t        key;
        iv_t         iv;
        block_t      plain;
        bypass_t     byp;
        block_t      expect_blk;
        logic [55:0] tok;  // Room for the word dropped
        fd = $fopen("gcm_input.txt", "r");
        if (fd == 0)
        begin
            abort_run("cannot open gcm_input.txt for reading");
        end
        else
        begin
            while (!$feof(fd))
            begin
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 8 && line.getc(0) != "#")  // Skip comments
                begin
                    code = $sscanf(line, "%b %b %b %h %h %h %h %s",
                                   v, n, l, key, iv, plain, byp, tok);
                    if (code != 8)
                    begin
                        abort_run($sformatf("badly formed vector line: %s", line));
                    end
                    else
                    begin
                        expect_blk = '0;
                        if (tok != "dropped")
                        begin
                            code = $sscanf(line, "%b %b %b %h %h %h %h %h",
                                           v, n, l, key, iv, plain, byp, expect_blk);
                        end
                        vec_valid.push_back(v);
                        vec_new.push_back(n);
                        vec_last.push_back(l);
                        vec_key.push_back(key);
                        vec_iv.push_back(iv);
                        vec_plain.push_back(plain);
                        vec_bypass.push_back(byp);
                        vec_expect.push_back(expect_blk);
                        vec_drop.push_back(tok == "dropped");
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_vector(input int idx);
        int      gap;
        int      cycles;
        logic    seen;
        bypass_t byp;
        gap = int'($urandom % 4);                                       // Idle 0..3 cycles
        byp = vec_bypass[idx] ^ {$urandom, $urandom, $urandom, $urandom};
        repeat (gap) @(posedge clk);
        @(posedge clk);
        i_valid       <= vec_valid[idx];
        i_new         <= vec_new[idx];
        i_last        <= vec_last[idx];
        i_key         <= vec_key[idx];
        i_iv          <= vec_iv[idx];
        i_plain_text  <= vec_plain[idx];
        i_bypass_text <= byp;
        @(posedge clk);  // Accepting edge
        i_valid <= 1'b0;
        i_new   <= 1'b0;
        i_last  <= 1'b0;
        if (vec_drop[idx])
        begin
            repeat (12)
            begin
                @(negedge clk);
                check_value("o_busy", 128'(o_busy), 128'(0));  // No core activity
                check_value("o_cp_ready", 128'(o_cp_ready), 128'(0));
            end
        end
        else
        begin
            cycles = 0;
            seen   = 1'b0;
            @(negedge clk);
            check_value("o_busy", 128'(o_busy), 128'(0));  // Core only just started
            while (!seen && cycles < READY_LIMIT)
            begin
                @(negedge clk);
                cycles++;  // Edges since the accepting edge
                seen = o_cp_ready;
                if (!seen)
                begin
                    check_value("o_busy", 128'(o_busy), 128'(cycles <= 10));  // Rounds 1..10
                end
            end
            if (!seen)
            begin
                abort_run($sformatf("DUT never signalled ready for vector %0d", idx));
            end
            else
            begin
                check_value("ready latency", 128'(cycles), 128'(11));
                check_value("o_busy", 128'(o_busy), 128'(0));  // Falls with ready
                check_value("o_cipher_text", o_cipher_text, vec_expect[idx]);
                check_value("o_bypass_text", o_bypass_text, byp);
                check_value("o_last", 128'(o_last), 128'(vec_last[idx]));
            end
        end
    endtask

    // Ends a run that stalls anywhere
    initial
    begin
        wait (loaded === 1'b1);
        repeat (num_vec * 20 + 100) @(posedge clk);
        abort_run("timeout: the DUT never reached the end of the vectors");
    end

    initial
    begin
        int unsigned seed;
        seed = 32'h9ffd_b118;
        void'($urandom(seed));  // Single seed for the whole run
        $timeformat(-9, 0, " ns", 0);
        loaded        = 1'b0;
        i_reset       <= 1'b1;
        i_valid       <= 1'b0;
        i_new         <= 1'b0;
        i_last        <= 1'b0;
        i_key         <= '0;
        i_iv          <= '0;
        i_plain_text  <= '0;
        i_bypass_text <= '0;
        load_vectors();
        num_vec = vec_valid.size();
        loaded  = 1'b1;
        repeat (2) @(posedge clk);
        i_reset <= 1'b0;
        @(negedge clk);
        check_value("o_busy", 128'(o_busy), 128'(0));  // Reset state
        check_value("o_cp_ready", 128'(o_cp_ready), 128'(0));
        check_value("o_last", 128'(o_last), 128'(0));
        check_value("o_cipher_text", o_cipher_text, 128'(0));
        check_value("o_bypass_text", o_bypass_text, 128'(0));
        for (int i = 0; i < num_vec; i++)
        begin
            run_vector(i);
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule
